// File: verilog/riscv_pkg.sv
package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;

    typedef enum logic [3:0] {
        MEM_NONE           = 4'd0,
        LOAD_BYTE          = 4'd1,
        LOAD_HALF          = 4'd2,
        LOAD_WORD          = 4'd3,
        LOAD_BYTE_UNSIGNED = 4'd4,
        LOAD_HALF_UNSIGNED = 4'd5,
        STORE_BYTE         = 4'd6,
        STORE_HALF         = 4'd7,
        STORE_WORD         = 4'd8
    } mem_op_t;

    // One bus word seen whole, as halves, or as byte lanes.
    typedef union packed {
        word_t            word;
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } lane_word_t;

    // Unprivileged, secure, data access.
    localparam prot_t PROT_DATA = 3'b000;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        word_t addr;
        prot_t prot;
    } axi_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        word_t addr;
        prot_t prot;
    } axi_ar_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
    } axi_r_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {LOAD_BYTE, LOAD_HALF, LOAD_WORD,
                          LOAD_BYTE_UNSIGNED, LOAD_HALF_UNSIGNED};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {STORE_BYTE, STORE_HALF, STORE_WORD};
    endfunction

endpackage

// File: verilog/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  riscv_pkg::mem_op_t op,
    input  riscv_pkg::word_t   addr,
    input  riscv_pkg::word_t   din,
    output riscv_pkg::strb_t   strb,
    output riscv_pkg::word_t   dout
);
    riscv_pkg::lane_word_t lanes;

    always_comb begin
        lanes.word = din;
        strb = '0;
        case (op)
            riscv_pkg::STORE_BYTE: begin
                // Byte copied to every lane with a single strobe bit.
                lanes.bytes = {4{din[7:0]}};
                strb = 4'b0001 << addr[1:0];
            end
            riscv_pkg::STORE_HALF: begin
                lanes.halves = {2{din[15:0]}};
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            riscv_pkg::STORE_WORD: begin
                strb = 4'b1111;
            end
            default: begin
                strb = '0;
            end
        endcase
    end

    assign dout = lanes.word;

endmodule

// File: verilog/load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  logic               clk,
    input  logic               capture,
    input  riscv_pkg::mem_op_t op,
    input  riscv_pkg::word_t   addr,
    input  riscv_pkg::word_t   din,
    output riscv_pkg::word_t   dout
);
    riscv_pkg::mem_op_t    ld_op;
    logic [1:0]            ld_off;
    riscv_pkg::lane_word_t lanes;
    logic [7:0]            sel_byte;
    logic [15:0]           sel_half;
    riscv_pkg::word_t      result;

    // Kind and offset of the load in flight.
    always_ff @(posedge clk) begin
        if (riscv_pkg::is_load(op)) begin
            ld_op  <= op;
            ld_off <= addr[1:0];
        end
    end

    always_comb begin
        lanes.word = din;
        sel_byte = lanes.bytes[ld_off];
        sel_half = lanes.halves[ld_off[1]];
        case (ld_op)
            riscv_pkg::LOAD_BYTE:          result = {{24{sel_byte[7]}}, sel_byte};
            riscv_pkg::LOAD_BYTE_UNSIGNED: result = {24'h000000, sel_byte};
            riscv_pkg::LOAD_HALF:          result = {{16{sel_half[15]}}, sel_half};
            riscv_pkg::LOAD_HALF_UNSIGNED: result = {16'h0000, sel_half};
            default:                       result = lanes.word;
        endcase
    end

    // Result held until the next load returns.
    always_ff @(posedge clk) begin
        if (capture) begin
            dout <= result;
        end
    end

endmodule

// File: verilog/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  logic                clk,
    input  logic                resetn,
    input  riscv_pkg::mem_op_t  op,
    input  riscv_pkg::word_t    addr,
    input  riscv_pkg::word_t    din,
    output riscv_pkg::word_t    dout,
    output logic                strb,
    output logic                idle,
    output riscv_pkg::axi_aw_t  aw,
    output logic                aw_valid,
    input  logic                aw_ready,
    output riscv_pkg::axi_w_t   w,
    output logic                w_valid,
    input  logic                w_ready,
    input  riscv_pkg::axi_b_t   b,
    input  logic                b_valid,
    output logic                b_ready,
    output riscv_pkg::axi_ar_t  ar,
    output logic                ar_valid,
    input  logic                ar_ready,
    input  riscv_pkg::axi_r_t   r,
    input  logic                r_valid,
    output logic                r_ready
);
    typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} state_t;

    state_t           wstate;
    state_t           wnext;
    state_t           rstate;
    state_t           rnext;
    logic             aw_valid_n;
    logic             w_valid_n;
    logic             b_ready_n;
    logic             ar_valid_n;
    logic             r_ready_n;
    logic             store;
    logic             load;
    logic             w_free;
    logic             r_free;
    logic             r_done;
    riscv_pkg::word_t st_data;
    riscv_pkg::strb_t st_strb;

    assign store = riscv_pkg::is_store(op);
    assign load  = riscv_pkg::is_load(op);

    // Write side is free again in the cycle its response is taken.
    assign w_free = wstate == IDLE || (wstate == RESP && b_valid && b.resp == riscv_pkg::RESP_OKAY);
    assign r_free = rstate == IDLE;
    assign r_done = r_ready && r_valid;
    assign idle   = w_free && r_free;

    // ----------------------------------------
    // Write channels
    // ----------------------------------------

    store_align u_store_align (
        .op   (op),
        .addr (addr),
        .din  (din),
        .strb (st_strb),
        .dout (st_data)
    );

    always_comb begin
        wnext      = wstate;
        aw_valid_n = aw_valid && !aw_ready;
        w_valid_n  = w_valid && !w_ready;
        b_ready_n  = b_ready;
        if (w_free) begin
            wnext      = store ? ADDR : IDLE;
            aw_valid_n = store;
            w_valid_n  = store;
            b_ready_n  = store;
        end else if (wstate == ADDR || wstate == DATA) begin
            // AW and W may finish in either order.
            if (!aw_valid_n && !w_valid_n) begin
                wnext = RESP;
            end else if (!aw_valid_n) begin
                wnext = DATA;
            end
        end
    end

    // ----------------------------------------
    // Read channels
    // ----------------------------------------

    always_comb begin
        rnext      = rstate;
        ar_valid_n = ar_valid && !ar_ready;
        r_ready_n  = r_ready && !r_valid;
        if (r_free) begin
            rnext      = load ? ADDR : IDLE;
            ar_valid_n = load;
            r_ready_n  = load;
        end else if (r_done) begin
            rnext = IDLE;
        end else if (!ar_valid_n) begin
            rnext = RESP;
        end
    end

    load_extract u_load_extract (
        .clk     (clk),
        .capture (r_done),
        .op      (op),
        .addr    (addr),
        .din     (r.data),
        .dout    (dout)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wstate   <= IDLE;
            rstate   <= IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            strb     <= 1'b0;
        end else begin
            wstate   <= wnext;
            rstate   <= rnext;
            aw_valid <= aw_valid_n;
            w_valid  <= w_valid_n;
            b_ready  <= b_ready_n;
            ar_valid <= ar_valid_n;
            r_ready  <= r_ready_n;
            strb     <= r_done;
        end
    end

    // Payloads latched as each machine leaves idle.
    always_ff @(posedge clk) begin
        if (w_free && store) begin
            aw.addr <= addr;
            aw.prot <= riscv_pkg::PROT_DATA;
            w.data  <= st_data;
            w.strb  <= st_strb;
        end
        if (r_free && load) begin
            ar.addr <= addr;
            ar.prot <= riscv_pkg::PROT_DATA;
        end
    end

endmodule

// File: verilog/axi_ram.sv
`timescale 1ns/1ps

module axi_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  riscv_pkg::axi_aw_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  riscv_pkg::axi_w_t  w,
    input  logic               w_valid,
    output logic               w_ready,
    output riscv_pkg::axi_b_t  b,
    output logic               b_valid,
    input  logic               b_ready,
    input  riscv_pkg::axi_ar_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output riscv_pkg::axi_r_t  r,
    output logic               r_valid,
    input  logic               r_ready
);
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_AR = 2;

    riscv_pkg::word_t mem [2**ADDR_WIDTH];

    logic             aw_held;
    logic             w_held;
    riscv_pkg::word_t waddr;
    riscv_pkg::word_t wdata;
    riscv_pkg::strb_t wstrb;
    riscv_pkg::word_t wr_addr;
    riscv_pkg::word_t wr_data;
    riscv_pkg::strb_t wr_strb;
    logic             wr_go;
    logic [2:0]       req_valid;
    logic [2:0]       req_open;
    logic [2:0]       req_ready;
    logic [1:0]       req_wait [3];
    logic [1:0]       wait_cnt [3];

    // ----------------------------------------
    // Ready delay of 0 to 3 cycles per request
    // ----------------------------------------

    assign wr_addr = aw_held ? waddr : aw.addr;
    assign wr_data = w_held ? wdata : w.data;
    assign wr_strb = w_held ? wstrb : w.strb;

    assign req_valid = {ar_valid, w_valid, aw_valid};
    assign req_open  = {!r_valid, !w_held && !b_valid, !aw_held && !b_valid};

    // W uses the inverted pattern so AW and W land in varying order.
    assign req_wait[CH_AW] = aw.addr[3:2];
    assign req_wait[CH_W]  = ~wr_addr[3:2];
    assign req_wait[CH_AR] = ar.addr[3:2];

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            req_ready[i] = req_valid[i] && req_open[i] && wait_cnt[i] == req_wait[i];
        end
    end

    assign aw_ready = req_ready[CH_AW];
    assign w_ready  = req_ready[CH_W];
    assign ar_ready = req_ready[CH_AR];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (!resetn) begin
                wait_cnt[i] <= '0;
            end else if (req_ready[i]) begin
                wait_cnt[i] <= '0;
            end else if (req_valid[i] && req_open[i]) begin
                wait_cnt[i] <= wait_cnt[i] + 2'd1;
            end
        end
    end

    // ----------------------------------------
    // Write and read responses
    // ----------------------------------------

    assign wr_go = (aw_held || aw_ready) && (w_held || w_ready);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                if (aw_ready) begin
                    aw_held <= 1'b1;
                end
                if (w_ready) begin
                    w_held <= 1'b1;
                end
            end
            if (ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_ready) begin
            waddr <= aw.addr;
        end
        if (w_ready) begin
            wdata <= w.data;
            wstrb <= w.strb;
        end
        if (wr_go) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_addr[ADDR_WIDTH+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
            b.resp <= riscv_pkg::RESP_OKAY;
        end
        if (ar_ready) begin
            r.data <= mem[ar.addr[ADDR_WIDTH+1:2]];
            r.resp <= riscv_pkg::RESP_OKAY;
        end
    end

endmodule

// File: verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  riscv_pkg::mem_op_t op,
    input  riscv_pkg::word_t   addr,
    input  riscv_pkg::word_t   din,
    output riscv_pkg::word_t   dout,
    output logic               strb,
    output logic               idle
);
    riscv_pkg::axi_aw_t aw;
    riscv_pkg::axi_w_t  w;
    riscv_pkg::axi_b_t  b;
    riscv_pkg::axi_ar_t ar;
    riscv_pkg::axi_r_t  r;
    logic aw_valid;
    logic aw_ready;
    logic w_valid;
    logic w_ready;
    logic b_valid;
    logic b_ready;
    logic ar_valid;
    logic ar_ready;
    logic r_valid;
    logic r_ready;

    // Load/store master on the core side.
    mem_access u_mem_access (
        .clk, .resetn, .op, .addr, .din, .dout, .strb, .idle,
        .aw, .aw_valid, .aw_ready,
        .w, .w_valid, .w_ready,
        .b, .b_valid, .b_ready,
        .ar, .ar_valid, .ar_ready,
        .r, .r_valid, .r_ready
    );

    axi_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_axi_ram (
        .clk, .resetn,
        .aw, .aw_valid, .aw_ready,
        .w, .w_valid, .w_ready,
        .b, .b_valid, .b_ready,
        .ar, .ar_valid, .ar_ready,
        .r, .r_valid, .r_ready
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Reset released on a rising edge after the hold time.
    initial begin
        resetn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    typedef struct packed {
        riscv_pkg::mem_op_t op;
        riscv_pkg::word_t   addr;
        riscv_pkg::word_t   din;
        riscv_pkg::word_t   result;
    } vector_t;

    logic               clk;
    logic               resetn;
    riscv_pkg::mem_op_t op;
    riscv_pkg::word_t   addr;
    riscv_pkg::word_t   din;
    riscv_pkg::word_t   dout;
    logic               strb;
    logic               idle;

    vector_t          vectors[$];
    logic [7:0]       model_mem [1024];
    int               error_count;
    int               check_count;
    int               cycle_count = 0;
    int               cycle_limit = 0;
    riscv_pkg::word_t last_load;
    logic             have_load;
    int               fd;

    tb_clock #(
        .PERIOD       (100),
        .RESET_CYCLES (8)
    ) u_tb_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    mem_subsystem #(
        .ADDR_WIDTH (8)
    ) u_mem_subsystem (
        .clk, .resetn, .op, .addr, .din, .dout, .strb, .idle
    );

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic check_word(input string name, input riscv_pkg::word_t expected,
                              input riscv_pkg::word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // Byte-array memory model
    // ----------------------------------------

    function automatic riscv_pkg::word_t model_load(vector_t v);
        logic [9:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        a  = v.addr[9:0];
        b0 = model_mem[a];
        b1 = model_mem[a + 10'd1];
        case (v.op)
            riscv_pkg::LOAD_BYTE:          model_load = {{24{b0[7]}}, b0};
            riscv_pkg::LOAD_BYTE_UNSIGNED: model_load = {24'h000000, b0};
            riscv_pkg::LOAD_HALF:          model_load = {{16{b1[7]}}, b1, b0};
            riscv_pkg::LOAD_HALF_UNSIGNED: model_load = {16'h0000, b1, b0};
            default: model_load = {model_mem[a + 10'd3], model_mem[a + 10'd2], b1, b0};
        endcase
    endfunction

    // Only the lanes covered by the access size change.
    task automatic model_store(input vector_t v);
        logic [9:0] a;
        a = v.addr[9:0];
        model_mem[a] = v.din[7:0];
        if (v.op != riscv_pkg::STORE_BYTE) begin
            model_mem[a + 10'd1] = v.din[15:8];
        end
        if (v.op == riscv_pkg::STORE_WORD) begin
            model_mem[a + 10'd2] = v.din[23:16];
            model_mem[a + 10'd3] = v.din[31:24];
        end
    endtask

    task automatic read_vectors(input int file);
        string            line;
        int               code;
        int               n;
        riscv_pkg::word_t v_addr;
        riscv_pkg::word_t v_din;
        riscv_pkg::word_t v_result;
        vector_t          v;
        while (!$feof(file)) begin
            line = "";
            n = $fgets(line, file);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h", code, v_addr, v_din, v_result) == 4) begin
                    v.op     = riscv_pkg::mem_op_t'(code[3:0]);
                    v.addr   = v_addr;
                    v.din    = v_din;
                    v.result = v_result;
                    vectors.push_back(v);
                end
            end
        end
    endtask

    // ----------------------------------------
    // One operation from issue to idle
    // ----------------------------------------

    task automatic run_vector(input int idx);
        vector_t          v;
        string            name;
        int               pulses;
        logic             load;
        riscv_pkg::word_t model_val;
        v    = vectors[idx];
        load = !(v.op inside {riscv_pkg::STORE_BYTE, riscv_pkg::STORE_HALF,
                              riscv_pkg::STORE_WORD});
        name = $sformatf("vector %0d %s at %08h", idx, v.op.name(), v.addr);
        @(posedge clk);
        while (!idle) begin
            @(posedge clk);
        end
        op   <= v.op;
        addr <= v.addr;
        din  <= v.din;
        @(posedge clk);
        op   <= riscv_pkg::MEM_NONE;
        addr <= '0;
        din  <= '0;
        pulses = 0;
        do begin
            @(posedge clk);
            if (strb) begin
                pulses++;
            end
            if (!load) begin
                check_flag({name, " strb"}, 1'b0, strb);
            end
        end while (!idle);
        if (load) begin
            model_val = model_load(v);
            check_word({name, " model"}, model_val, v.result);
            check_word(name, v.result, dout);
            check_count++;
            if (pulses != 1) begin
                error_count++;
                $display("Load %s finished with %0d strb pulses instead of one.", name, pulses);
            end
            last_load = v.result;
            have_load = 1'b1;
        end else begin
            model_store(v);
            if (have_load) begin
                check_word({name, " dout held"}, last_load, dout);
            end
        end
    endtask

    // Run limit scales with the number of vectors.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d errors so far.", cycle_count, error_count);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        op          <= riscv_pkg::MEM_NONE;
        addr        <= '0;
        din         <= '0;
        error_count = 0;
        check_count = 0;
        have_load   = 1'b0;
        last_load   = '0;
        fd = $fopen("tests/mem_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/mem_input.txt for reading.");
            $display("Verification failed");
            $finish;
        end else begin
            read_vectors(fd);
            $fclose(fd);
            cycle_limit = vectors.size() * 20 + 100;
            do begin
                @(posedge clk);
            end while (!resetn);
            check_flag("reset idle", 1'b1, idle);
            check_flag("reset strb", 1'b0, strb);
            foreach (vectors[i]) begin
                run_vector(i);
            end
            $display("Vectors: %0d, checks: %0d, errors: %0d",
                     vectors.size(), check_count, error_count);
            if (error_count == 0 && vectors.size() > 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// File: tests/mem_input.txt
# Columns: op code (hex), byte address, store data, expected load result.
# Op codes: 1 LB, 2 LH, 3 LW, 4 LBU, 5 LHU, 6 SB, 7 SH, 8 SW; stores expect 0.
8 00000000 11223344 00000000
3 00000000 00000000 11223344
8 00000004 a5b6c7d8 00000000
3 00000004 00000000 a5b6c7d8
8 00000008 deadbeef 00000000
3 00000008 00000000 deadbeef
8 0000000c 0badf00d 00000000
3 0000000c 00000000 0badf00d
8 000003fc cafef00d 00000000
3 000003fc 00000000 cafef00d
6 00000010 000000aa 00000000
6 00000011 12345655 00000000
6 00000012 000000ff 00000000
6 00000013 ffffff01 00000000
3 00000010 00000000 01ff55aa
7 00000010 12348001 00000000
3 00000010 00000000 01ff8001
7 00000012 00007f3e 00000000
3 00000010 00000000 7f3e8001
1 00000011 00000000 ffffff80
4 00000011 00000000 00000080
1 00000013 00000000 0000007f
4 00000010 00000000 00000001
2 00000010 00000000 ffff8001
5 00000010 00000000 00008001
2 00000012 00000000 00007f3e
5 00000012 00000000 00007f3e
1 0000000a 00000000 ffffffad
2 0000000a 00000000 ffffdead
6 0000000e 00000099 00000000
3 0000000c 00000000 0b99f00d

// File: files.f
verilog/riscv_pkg.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/mem_access.sv
verilog/axi_ram.sv
verilog/mem_subsystem.sv
tests/tb_clock.sv
tests/tb_mem_subsystem.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_mem_subsystem
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

SOURCES := $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
